/* Bender.yml */
package:
  name: task_injector

sources:
  - hw/noc_pkg.sv
  - hw/app_pkg.sv
  - hw/alloc_receiver.sv
  - hw/task_sequencer.sv
  - hw/packet_sender.sv
  - hw/task_injector.sv
  - target: simulation
    files:
      - dv/tb_task_injector.sv

/* dv/tb_task_injector.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Task injector testbench.
// Random loader and mapper traffic, a queue model of the
// allocation packets, and flit-by-flit output checks.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_task_injector
    import noc_pkg::*;
    import app_pkg::*;
;

    localparam int unsigned MAX_PAYLOAD = 32;

    logic        clk_i;
    logic        rst_ni;
    logic        src_rx_i;
    flit_t       src_data_i;
    logic        src_credit_o;
    logic [15:0] mapper_addr;
    logic        noc_tx_o;
    logic        noc_eop_o;
    logic        noc_credit_i;
    flit_t       noc_data_o;
    logic        noc_rx_i;
    logic        noc_eop_i;
    logic        noc_credit_o;
    flit_t       noc_data_i;

    integer      seed;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          out_cnt;
    int          cycle_cnt;
    int          cycle_limit = 50;  // Reset and the reset check.
    logic        bp_en;
    logic        gap_en;
    flit_t       exp_data;
    logic        exp_eop;

    flit_t       ld_q[$];      // Loader words.
    flit_t       net_q[$];     // Mapper flits.
    logic        net_eop_q[$];
    flit_t       exp_q[$];     // Predicted output flits.
    logic        exp_eop_q[$];

    task_injector #(
        .MAX_PAYLOAD_SIZE (MAX_PAYLOAD)
    ) DUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .src_rx_i         (src_rx_i),
        .src_data_i       (src_data_i),
        .src_credit_o     (src_credit_o),
        .mapper_address_i (mapper_addr),
        .noc_tx_o         (noc_tx_o),
        .noc_eop_o        (noc_eop_o),
        .noc_credit_i     (noc_credit_i),
        .noc_data_o       (noc_data_o),
        .noc_rx_i         (noc_rx_i),
        .noc_eop_i        (noc_eop_i),
        .noc_credit_o     (noc_credit_o),
        .noc_data_i       (noc_data_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Network output back-pressure.
    initial begin
        forever begin
            @(posedge clk_i);
            noc_credit_i <= bp_en ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    always @(negedge clk_i) begin
        if (rst_ni && noc_tx_o && noc_credit_i) begin
            assert (exp_q.size() > 0) else begin
                $display("Flit %h left the injector when no packet was due, at %0t",
                         noc_data_o, $time);
                err_cnt++;
            end
            if (exp_q.size() > 0) begin
                exp_data = exp_q.pop_front();
                exp_eop  = exp_eop_q.pop_front();
                assert (noc_data_o == exp_data) else begin
                    $display("ERROR @%0t: flit %0d data %h, expected %h",
                             $time, out_cnt, noc_data_o, exp_data);
                    err_cnt++;
                end
                assert (noc_eop_o == exp_eop) else begin
                    $display("ERROR @%0t: flit %0d eop %b, expected %b",
                             $time, out_cnt, noc_eop_o, exp_eop);
                    err_cnt++;
                end
            end
            out_cnt++;
        end
    end

    task automatic push_net(input flit_t w, input logic eop);
        net_q.push_back(w);
        net_eop_q.push_back(eop);
    endtask

    task automatic push_exp(input flit_t w, input logic eop);
        exp_q.push_back(w);
        exp_eop_q.push_back(eop);
    endtask

    task automatic push_delivery_header(input flit_t service, input int payload_len);
        int k;
        for (k = 0; k < HEADER_FLITS; k++) begin
            if (k == HDR_SERVICE) begin
                push_net(service, 1'b0);
            end else if (k == HDR_PAYLOAD_SIZE) begin
                push_net(payload_len, 1'b0);
            end else begin
                push_net($random(seed), 1'b0);
            end
        end
    endtask

    // Mapper packet that must not lead to an allocation.
    task automatic add_foreign_packet(input flit_t service, input flit_t kernel, input int len);
        int k;
        push_delivery_header(service, len);
        push_net(kernel, 1'b0);
        for (k = 1; k < len; k++) begin
            if (k % MAX_PAYLOAD == 0) begin
                push_net(kernel, k == len - 1);  // Lands on word 0 if the buffer wraps.
            end else begin
                push_net($random(seed), k == len - 1);
            end
        end
    endtask

    // One application: loader words, mapper delivery and predicted packets.
    task automatic add_app(input int n_tasks, input int empty_idx);
        flit_t     hdr [HEADER_FLITS];
        task_idx_t app_id;
        flit_t     word;
        flit_t     tgt;
        flit_t     text_sz;
        flit_t     data_sz;
        flit_t     bss_sz;
        flit_t     entry;
        int        i;
        int        k;
        int        words;
        app_id = $random(seed);
        push_delivery_header(MESSAGE_DELIVERY, n_tasks + 2);
        push_net(APP_ALLOCATION_REQUEST, 1'b0);
        word      = $random(seed);
        word[7:0] = app_id;  // Upper bits are noise.
        push_net(word, 1'b0);
        ld_q.push_back(n_tasks);
        for (i = 0; i < n_tasks; i++) begin
            tgt     = $random(seed);
            text_sz = $random(seed) & 32'h1C;
            data_sz = $random(seed) & 32'h0C;
            bss_sz  = $random(seed) & 32'hFFC;
            entry   = $random(seed) & 32'hFFFC;
            if (i == empty_idx) begin
                text_sz = '0;
                data_sz = '0;
            end
            push_net(tgt, i == n_tasks - 1);
            ld_q.push_back(text_sz);
            ld_q.push_back(data_sz);
            ld_q.push_back(bss_sz);
            ld_q.push_back(entry);
            words = (text_sz + data_sz) / 4;
            for (k = 0; k < HEADER_FLITS; k++) begin
                hdr[k] = '0;
            end
            hdr[HDR_TARGET]       = tgt;
            hdr[HDR_PAYLOAD_SIZE] = words + 11;
            hdr[HDR_SERVICE]      = TASK_ALLOCATION;
            hdr[HDR_TASK_ID]      = {16'h0000, app_id, i[7:0]};
            hdr[HDR_MAPPER]       = {16'h0000, mapper_addr};
            hdr[HDR_DATA_SZ]      = data_sz;
            hdr[HDR_TEXT_SZ]      = text_sz;
            hdr[HDR_BSS_SZ]       = bss_sz;
            hdr[HDR_ENTRY]        = entry;
            for (k = 0; k < HEADER_FLITS; k++) begin
                push_exp(hdr[k], (k == HEADER_FLITS - 1) && (words == 0));
            end
            for (k = 0; k < words; k++) begin
                word = $random(seed);
                ld_q.push_back(word);
                push_exp(word, k == words - 1);
            end
        end
    endtask

    task automatic drive_loader();
        flit_t w;
        int    gap;
        while (ld_q.size() > 0) begin
            w   = ld_q.pop_front();
            gap = gap_en ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                @(posedge clk_i);
                src_rx_i <= 1'b0;
            end
            @(posedge clk_i);
            src_rx_i   <= 1'b1;
            src_data_i <= w;
            @(negedge clk_i);
            while (!src_credit_o) @(negedge clk_i);
        end
        @(posedge clk_i);
        src_rx_i <= 1'b0;
    endtask

    task automatic drive_network();
        flit_t w;
        logic  eop;
        logic  first;
        int    gap;
        first = 1'b1;
        while (net_q.size() > 0) begin
            w   = net_q.pop_front();
            eop = net_eop_q.pop_front();
            gap = gap_en ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                @(posedge clk_i);
                noc_rx_i <= 1'b0;
            end
            @(posedge clk_i);
            noc_rx_i   <= 1'b1;
            noc_data_i <= w;
            noc_eop_i  <= eop;
            @(negedge clk_i);
            while (!noc_credit_o) begin
                assert (first) else begin
                    $display("Receive credit dropped inside a packet at %0t", $time);
                    err_cnt++;
                end
                @(negedge clk_i);
            end
            first = eop;
        end
        @(posedge clk_i);
        noc_rx_i  <= 1'b0;
        noc_eop_i <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%-24s passed", name);
        end else begin
            fail_cnt++;
            $display("%-24s failed, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic run_test(input string name);
        int errs_before;
        errs_before = err_cnt;
        cycle_limit += (ld_q.size() + net_q.size() + exp_q.size()) * 4 + 50;
        fork
            drive_loader();
            drive_network();
        join
        wait (exp_q.size() == 0);
        repeat (5) @(posedge clk_i);
        report_test(name, errs_before);
    endtask

    initial begin
        seed         = 73;
        err_cnt      = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        out_cnt      = 0;
        bp_en        = 1'b0;
        gap_en       = 1'b0;
        rst_ni       = 1'b0;
        src_rx_i     = 1'b0;
        src_data_i   = '0;
        noc_rx_i     = 1'b0;
        noc_eop_i    = 1'b0;
        noc_data_i   = '0;
        noc_credit_i = 1'b1;
        mapper_addr  = $random(seed);
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        assert (src_credit_o && !noc_tx_o && !noc_eop_o && !noc_credit_o) else begin
            $display("ERROR @%0t: reset values credit %b tx %b eop %b rx credit %b",
                     $time, src_credit_o, noc_tx_o, noc_eop_o, noc_credit_o);
            err_cnt++;
        end
        report_test("reset values", 0);

        add_foreign_packet(TASK_ALLOCATION, APP_ALLOCATION_REQUEST, 4);  // Wrong service.
        add_foreign_packet(MESSAGE_DELIVERY, ~APP_ALLOCATION_REQUEST, 4);
        ld_q.push_back('0);  // Zero task count.
        add_app(2, -1);
        run_test("ignored packets");

        add_foreign_packet(MESSAGE_DELIVERY, APP_ALLOCATION_REQUEST, MAX_PAYLOAD + 3);
        add_app(3, -1);
        run_test("oversized drop");

        add_app(4, 2);
        run_test("full application");

        bp_en  = 1'b1;
        gap_en = 1'b1;
        add_app(3, -1);
        add_app(2, -1);
        run_test("back-pressure");

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hw/alloc_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Allocation receiver.
// Accepts packets from the network while armed, buffers the payload,
// drops packets that overflow and flags allocation deliveries.
// Task targets are read back from the payload buffer.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alloc_receiver
    import noc_pkg::*;
    import app_pkg::*;
#(
    parameter int unsigned MAX_PAYLOAD_SIZE = 32
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      arm_i,
    input  logic      noc_rx_i,
    input  logic      noc_eop_i,
    input  flit_t     noc_data_i,
    output logic      noc_credit_o,
    input  task_idx_t task_idx_i,
    output logic      alloc_valid_o,
    output task_idx_t app_id_o,
    output flit_t     target_o
);

    localparam int unsigned PTR_W = $clog2(MAX_PAYLOAD_SIZE);
    localparam int unsigned HDR_W = $clog2(HEADER_FLITS);

    typedef enum logic [2:0] {
        RX_LISTEN,
        RX_HEADER,
        RX_PAYLOAD,
        RX_DROP,
        RX_DECIDE
    } rx_state_e;

    rx_state_e               state_q;
    rx_state_e               state_d;
    logic [HDR_W-1:0]        hdr_cnt_q;
    logic [PTR_W-1:0]        pay_cnt_q;
    flit_t                   service_q;
    flit_t                   payload_q [MAX_PAYLOAD_SIZE];
    logic                    flit_in;
    logic                    is_alloc;
    logic [TASK_CNT_WIDTH:0] tgt_sel;

    assign noc_credit_o = state_q inside {RX_HEADER, RX_PAYLOAD, RX_DROP};
    assign flit_in      = noc_rx_i && noc_credit_o;

    assign is_alloc = (service_q == MESSAGE_DELIVERY)
                   && (payload_q[0] == APP_ALLOCATION_REQUEST);
    assign alloc_valid_o = (state_q == RX_DECIDE) && is_alloc;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_LISTEN: begin
                if (arm_i) state_d = RX_HEADER;
            end
            RX_HEADER: begin
                if (flit_in) begin
                    if (noc_eop_i) begin
                        state_d = RX_LISTEN;  // No payload to decode.
                    end else if (hdr_cnt_q == HDR_W'(HEADER_FLITS - 1)) begin
                        state_d = RX_PAYLOAD;
                    end
                end
            end
            RX_PAYLOAD: begin
                if (flit_in) begin
                    if (noc_eop_i) begin
                        state_d = RX_DECIDE;
                    end else if (pay_cnt_q == PTR_W'(MAX_PAYLOAD_SIZE - 1)) begin
                        state_d = RX_DROP;    // Buffer full.
                    end
                end
            end
            RX_DROP: begin
                if (flit_in && noc_eop_i) state_d = RX_LISTEN;
            end
            RX_DECIDE: state_d = RX_LISTEN;
            default:   state_d = RX_LISTEN;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= RX_LISTEN;
            hdr_cnt_q <= '0;
            pay_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == RX_LISTEN) begin
                hdr_cnt_q <= '0;
                pay_cnt_q <= '0;
            end else if (flit_in && state_q == RX_HEADER) begin
                hdr_cnt_q <= hdr_cnt_q + 1'b1;
            end else if (flit_in && state_q == RX_PAYLOAD) begin
                pay_cnt_q <= pay_cnt_q + 1'b1;
            end
        end
    end

    // Only the service flit is needed for the decode.
    always_ff @(posedge clk_i) begin
        if (flit_in && state_q == RX_HEADER && hdr_cnt_q == HDR_W'(HDR_SERVICE)) begin
            service_q <= noc_data_i;
        end
        if (flit_in && state_q == RX_PAYLOAD) begin
            payload_q[pay_cnt_q] <= noc_data_i;
        end
    end

    assign app_id_o = payload_q[1][TASK_CNT_WIDTH-1:0];

    // Targets start at payload word 2.
    assign tgt_sel  = task_idx_i + 2'd2;
    assign target_o = (tgt_sel < MAX_PAYLOAD_SIZE) ? payload_q[PTR_W'(tgt_sel)] : '0;

endmodule

/* hw/app_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Application format.
// Task indexing, descriptor layout and mapper kernel codes.
// ~~~~~~~~~~~~~~~~~~~~

package app_pkg;

    localparam int unsigned TASK_CNT_WIDTH = 8;

    typedef logic [TASK_CNT_WIDTH-1:0] task_idx_t;

    // Descriptor words in loader order.
    localparam int unsigned DESC_WORDS   = 4;
    localparam int unsigned DESC_TEXT_SZ = 0;
    localparam int unsigned DESC_DATA_SZ = 1;
    localparam int unsigned DESC_BSS_SZ  = 2;
    localparam int unsigned DESC_ENTRY   = 3;

    // Kernel code in payload word 0 of a delivery.
    localparam logic [31:0] APP_ALLOCATION_REQUEST = 32'h0000_0042;

endpackage

/* hw/noc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Network packet format.
// Flit type, header layout and service codes.
// ~~~~~~~~~~~~~~~~~~~~

package noc_pkg;

    localparam int unsigned FLIT_WIDTH = 32;

    typedef logic [FLIT_WIDTH-1:0] flit_t;

    localparam int unsigned HEADER_FLITS = 13;

    // Header flit positions.
    localparam int unsigned HDR_TARGET       = 0;
    localparam int unsigned HDR_PAYLOAD_SIZE = 1;
    localparam int unsigned HDR_SERVICE      = 2;
    localparam int unsigned HDR_TASK_ID      = 3;
    localparam int unsigned HDR_MAPPER       = 4;
    localparam int unsigned HDR_DATA_SZ      = 9;
    localparam int unsigned HDR_TEXT_SZ      = 10;
    localparam int unsigned HDR_BSS_SZ       = 11;
    localparam int unsigned HDR_ENTRY        = 12;

    // Service codes.
    localparam flit_t MESSAGE_DELIVERY = 32'h0000_0002;
    localparam flit_t TASK_ALLOCATION  = 32'h0000_0040;

endpackage

/* hw/packet_sender.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Packet sender.
// Sends the task-allocation header followed by the task body
// streamed from the loader.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module packet_sender
    import noc_pkg::*;
    import app_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        start_i,
    input  flit_t       target_i,
    input  task_idx_t   app_id_i,
    input  task_idx_t   task_idx_i,
    input  logic [15:0] mapper_address_i,
    input  flit_t       text_sz_i,
    input  flit_t       data_sz_i,
    input  flit_t       bss_sz_i,
    input  flit_t       entry_i,
    input  logic        src_rx_i,
    input  flit_t       src_data_i,
    input  logic        noc_credit_i,
    output logic        noc_tx_o,
    output logic        noc_eop_o,
    output flit_t       noc_data_o,
    output logic        body_credit_o,
    output logic        done_o
);

    localparam int unsigned HDR_W = $clog2(HEADER_FLITS);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_BODY,
        TX_DONE
    } tx_state_e;

    tx_state_e        state_q;
    tx_state_e        state_d;
    logic [HDR_W-1:0] hdr_idx_q;
    flit_t            body_cnt_q;
    flit_t            target_q;
    flit_t            task_id_q;
    flit_t            mapper_q;
    flit_t            text_sz_q;
    flit_t            data_sz_q;
    flit_t            bss_sz_q;
    flit_t            entry_q;
    flit_t            hdr_flit;
    logic             last_hdr;
    logic             flit_out;

    assign last_hdr = hdr_idx_q == HDR_W'(HEADER_FLITS - 1);
    assign flit_out = noc_tx_o && noc_credit_i;
    assign done_o   = state_q == TX_DONE;

    always_comb begin
        case (hdr_idx_q)
            HDR_TARGET:       hdr_flit = target_q;
            HDR_PAYLOAD_SIZE: hdr_flit = body_cnt_q + FLIT_WIDTH'(HEADER_FLITS - 2);
            HDR_SERVICE:      hdr_flit = TASK_ALLOCATION;
            HDR_TASK_ID:      hdr_flit = task_id_q;
            HDR_MAPPER:       hdr_flit = mapper_q;
            HDR_DATA_SZ:      hdr_flit = data_sz_q;
            HDR_TEXT_SZ:      hdr_flit = text_sz_q;
            HDR_BSS_SZ:       hdr_flit = bss_sz_q;
            HDR_ENTRY:        hdr_flit = entry_q;
            default:          hdr_flit = '0;
        endcase
    end

    always_comb begin
        noc_tx_o      = 1'b0;
        noc_eop_o     = 1'b0;
        noc_data_o    = hdr_flit;
        body_credit_o = 1'b0;
        case (state_q)
            TX_HEADER: begin
                noc_tx_o  = 1'b1;
                noc_eop_o = last_hdr && (body_cnt_q == '0);  // Empty body.
            end
            TX_BODY: begin
                noc_tx_o      = src_rx_i;
                noc_eop_o     = src_rx_i && (body_cnt_q == FLIT_WIDTH'(1));
                noc_data_o    = src_data_i;
                body_credit_o = noc_credit_i;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TX_IDLE:   if (start_i) state_d = TX_HEADER;
            TX_HEADER: begin
                if (flit_out && last_hdr) begin
                    state_d = (body_cnt_q == '0) ? TX_DONE : TX_BODY;
                end
            end
            TX_BODY:   if (flit_out && body_cnt_q == FLIT_WIDTH'(1)) state_d = TX_DONE;
            TX_DONE:   state_d = TX_IDLE;
            default:   state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= TX_IDLE;
            hdr_idx_q  <= '0;
            body_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q != TX_HEADER) begin
                hdr_idx_q <= '0;
            end else if (flit_out) begin
                hdr_idx_q <= hdr_idx_q + 1'b1;
            end
            if (state_q == TX_IDLE && start_i) begin
                body_cnt_q <= (text_sz_i + data_sz_i) >> 2;  // Bytes to words.
            end else if (state_q == TX_BODY && flit_out) begin
                body_cnt_q <= body_cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == TX_IDLE && start_i) begin
            target_q  <= target_i;
            task_id_q <= {{(FLIT_WIDTH - 2 * TASK_CNT_WIDTH){1'b0}}, app_id_i, task_idx_i};
            mapper_q  <= {{(FLIT_WIDTH - 16){1'b0}}, mapper_address_i};
            text_sz_q <= text_sz_i;
            data_sz_q <= data_sz_i;
            bss_sz_q  <= bss_sz_i;
            entry_q   <= entry_i;
        end
    end

endmodule

/* hw/task_injector.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Task injector top level.
// Loader in, allocation packets out, mapper deliveries in.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module task_injector
    import noc_pkg::*;
    import app_pkg::*;
#(
    parameter int unsigned MAX_PAYLOAD_SIZE = 32
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        src_rx_i,
    input  flit_t       src_data_i,
    output logic        src_credit_o,
    input  logic [15:0] mapper_address_i,
    output logic        noc_tx_o,
    output logic        noc_eop_o,
    input  logic        noc_credit_i,
    output flit_t       noc_data_o,
    input  logic        noc_rx_i,
    input  logic        noc_eop_i,
    output logic        noc_credit_o,
    input  flit_t       noc_data_i
);

    logic      arm;
    logic      alloc_valid;
    task_idx_t app_id;
    task_idx_t task_idx;
    flit_t     target;
    logic      start;
    flit_t     text_sz;
    flit_t     data_sz;
    flit_t     bss_sz;
    flit_t     entry;
    logic      body_credit;
    logic      done;

    alloc_receiver #(
        .MAX_PAYLOAD_SIZE (MAX_PAYLOAD_SIZE)
    ) u_alloc_receiver (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .arm_i         (arm),
        .noc_rx_i      (noc_rx_i),
        .noc_eop_i     (noc_eop_i),
        .noc_data_i    (noc_data_i),
        .noc_credit_o  (noc_credit_o),
        .task_idx_i    (task_idx),
        .alloc_valid_o (alloc_valid),
        .app_id_o      (app_id),
        .target_o      (target)
    );

    task_sequencer u_task_sequencer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .src_rx_i      (src_rx_i),
        .src_data_i    (src_data_i),
        .src_credit_o  (src_credit_o),
        .arm_o         (arm),
        .alloc_valid_i (alloc_valid),
        .task_idx_o    (task_idx),
        .start_o       (start),
        .text_sz_o     (text_sz),
        .data_sz_o     (data_sz),
        .bss_sz_o      (bss_sz),
        .entry_o       (entry),
        .body_credit_i (body_credit),
        .done_i        (done)
    );

    packet_sender u_packet_sender (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .start_i          (start),
        .target_i         (target),
        .app_id_i         (app_id),
        .task_idx_i       (task_idx),
        .mapper_address_i (mapper_address_i),
        .text_sz_i        (text_sz),
        .data_sz_i        (data_sz),
        .bss_sz_i         (bss_sz),
        .entry_i          (entry),
        .src_rx_i         (src_rx_i),
        .src_data_i       (src_data_i),
        .noc_credit_i     (noc_credit_i),
        .noc_tx_o         (noc_tx_o),
        .noc_eop_o        (noc_eop_o),
        .noc_data_o       (noc_data_o),
        .body_credit_o    (body_credit),
        .done_o           (done)
    );

endmodule

/* hw/task_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Task sequencer.
// Reads the task count and per-task descriptors from the loader,
// waits for the allocation and launches one packet per task.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module task_sequencer
    import noc_pkg::*;
    import app_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      src_rx_i,
    input  flit_t     src_data_i,
    output logic      src_credit_o,
    output logic      arm_o,
    input  logic      alloc_valid_i,
    output task_idx_t task_idx_o,
    output logic      start_o,
    output flit_t     text_sz_o,
    output flit_t     data_sz_o,
    output flit_t     bss_sz_o,
    output flit_t     entry_o,
    input  logic      body_credit_i,
    input  logic      done_i
);

    localparam int unsigned DESC_CNT_W = $clog2(DESC_WORDS);

    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_WAIT_ALLOC,
        SQ_DESC,
        SQ_NEXT,
        SQ_SEND
    } seq_state_e;

    seq_state_e            state_q;
    seq_state_e            state_d;
    task_idx_t             task_cnt_q;
    task_idx_t             task_idx_q;
    logic [DESC_CNT_W-1:0] desc_cnt_q;
    flit_t                 text_sz_q;
    flit_t                 data_sz_q;
    flit_t                 bss_sz_q;
    flit_t                 entry_q;
    logic                  word_in;
    logic                  cnt_ok;
    logic                  last_desc;

    always_comb begin
        case (state_q)
            SQ_IDLE, SQ_DESC: src_credit_o = 1'b1;
            SQ_SEND:          src_credit_o = body_credit_i;  // Body streams through.
            default:          src_credit_o = 1'b0;
        endcase
    end

    assign word_in   = src_rx_i && src_credit_o;
    assign cnt_ok    = src_data_i[TASK_CNT_WIDTH-1:0] != '0;
    assign last_desc = desc_cnt_q == DESC_CNT_W'(DESC_WORDS - 1);

    // Armed already in the count cycle so receive credit opens a cycle later.
    assign arm_o = (state_q == SQ_WAIT_ALLOC)
                || (state_q == SQ_IDLE && word_in && cnt_ok);

    always_comb begin
        state_d = state_q;
        case (state_q)
            SQ_IDLE: begin
                if (word_in && cnt_ok) state_d = SQ_WAIT_ALLOC;
            end
            SQ_WAIT_ALLOC: begin
                if (alloc_valid_i) state_d = SQ_DESC;
            end
            SQ_DESC: begin
                if (word_in && last_desc) state_d = SQ_NEXT;
            end
            SQ_NEXT: state_d = SQ_SEND;
            SQ_SEND: begin
                if (done_i) begin
                    state_d = (task_idx_q == task_cnt_q) ? SQ_IDLE : SQ_DESC;
                end
            end
            default: state_d = SQ_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= SQ_IDLE;
            task_cnt_q <= '0;
            task_idx_q <= '0;
            desc_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == SQ_IDLE) begin
                task_idx_q <= '0;
                if (word_in) task_cnt_q <= src_data_i[TASK_CNT_WIDTH-1:0];
            end else if (state_q == SQ_NEXT) begin
                task_idx_q <= task_idx_q + 1'b1;  // Advance once the packet is launched.
            end
            if (state_q != SQ_DESC) begin
                desc_cnt_q <= '0;
            end else if (word_in) begin
                desc_cnt_q <= desc_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == SQ_DESC && word_in) begin
            case (desc_cnt_q)
                DESC_TEXT_SZ: text_sz_q <= src_data_i;
                DESC_DATA_SZ: data_sz_q <= src_data_i;
                DESC_BSS_SZ:  bss_sz_q  <= src_data_i;
                DESC_ENTRY:   entry_q   <= src_data_i;
                default: ;
            endcase
        end
    end

    assign start_o    = state_q == SQ_NEXT;
    assign task_idx_o = task_idx_q;
    assign text_sz_o  = text_sz_q;
    assign data_sz_o  = data_sz_q;
    assign bss_sz_o   = bss_sz_q;
    assign entry_o    = entry_q;

endmodule

/* vlog.f */
hw/noc_pkg.sv
hw/app_pkg.sv
hw/alloc_receiver.sv
hw/task_sequencer.sv
hw/packet_sender.sv
hw/task_injector.sv
dv/tb_task_injector.sv
